/* build.f */
source/board_io_pkg.sv
source/mem_bus_if.sv
source/apb_access_fsm.sv
source/data_mem.sv
source/io_regs.sv
source/row_scan_timer.sv
source/led_matrix_drive.sv
source/board_io_top.sv
verification/board_io_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the board I/O testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module board_io_tb \
  -f build.f \
  -Mdir obj_dir

./obj_dir/Vboard_io_tb > sim.log 2>&1
cat sim.log

if grep -q "^all tests passed$" sim.log; then
  echo "simulation PASS"
  exit 0
else
  echo "simulation FAIL"
  exit 1
fi

/* source/apb_access_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_access_fsm (
  input  wire                              sys_clk,
  input  wire                              rst_n,
  input  wire                              psel,
  input  wire                              penable,
  input  wire                              pwrite,
  input  wire [board_io_pkg::addr_w-1:0]   paddr,
  input  wire [board_io_pkg::data_w-1:0]   pwdata,
  input  wire [board_io_pkg::strb_w-1:0]   pstrb,
  output logic [board_io_pkg::data_w-1:0]  prdata,
  output logic                             pready,
  output logic                             pslverr,
  mem_bus_if.ctrl                          bus
);

  localparam int region_bit = board_io_pkg::addr_w - 1;

  typedef enum logic [1:0] {
    st_idle,
    st_request,  // A1
    st_respond   // A2
  } state_t;

  state_t state;
  logic   req_q;
  logic   sel_mem_q;
  logic   sel_io_q;

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= st_idle;
      req_q     <= 1'b0;
      sel_mem_q <= 1'b0;
      sel_io_q  <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (psel && !penable) begin // setup phase seen
            state     <= st_request;
            req_q     <= 1'b1;
            sel_mem_q <= !paddr[region_bit];
            sel_io_q  <= paddr[region_bit];
          end
        end
        st_request: begin
          state <= st_respond;
          req_q <= 1'b0;
        end
        default: begin
          state     <= st_idle;
          sel_mem_q <= 1'b0;
          sel_io_q  <= 1'b0;
        end
      endcase
    end
  end

  // requester holds address and data until pready
  assign bus.req     = req_q;
  assign bus.we      = pwrite;
  assign bus.strb    = pstrb;
  assign bus.addr    = paddr;
  assign bus.wdata   = pwdata;
  assign bus.sel_mem = sel_mem_q;
  assign bus.sel_io  = sel_io_q;

  assign pready  = (state == st_respond);
  assign pslverr = pready && sel_io_q && bus.io_err;

  always_comb begin
    if (sel_mem_q)
      prdata = bus.mem_rdata;
    else if (sel_io_q)
      prdata = bus.io_rdata;
    else
      prdata = '0;
  end

  a_penable_needs_psel : assert property (
    @(posedge sys_clk) disable iff (!rst_n) penable |-> psel);

  a_sel_exclusive : assert property (
    @(posedge sys_clk) disable iff (!rst_n) !(bus.sel_mem && bus.sel_io));

endmodule

`default_nettype wire

/* source/board_io_pkg.sv */
`default_nettype none

package board_io_pkg;

  // APB word addressing, 16-bit data with two byte lanes
  localparam int addr_w = 8;
  localparam int data_w = 16;
  localparam int strb_w = 2;

  // 0x00..0x7F data memory, bit 7 set selects the I/O region
  localparam int mem_words = 128;

  localparam logic [addr_w-1:0] io_led_lcd_addr = 8'h80; // {lcd, led}
  localparam logic [addr_w-1:0] io_gpio_addr    = 8'h81; // {0, gpio}

  // LED matrix geometry
  localparam int num_rows = 5;

  typedef logic [2:0] row_idx_t;

  // fixed one-hot columns for rows 0..3, entry 0 is row 0
  localparam logic [3:0][7:0] row_pattern = {
    8'h10,
    8'h20,
    8'h40,
    8'h80
  };

endpackage

`default_nettype wire

/* source/board_io_top.sv */
`timescale 1ns/1ps
`default_nettype none

module board_io_top #(
  parameter int PERIOD  = 27000,
  parameter int GAP_ON  = 100,
  parameter int GAP_OFF = 2000
) (
  input  wire                                    sys_clk,
  input  wire                                    rst_n,
  input  wire                                    psel,
  input  wire                                    penable,
  input  wire                                    pwrite,
  input  wire [board_io_pkg::addr_w-1:0]         paddr,
  input  wire [board_io_pkg::data_w-1:0]         pwdata,
  input  wire [board_io_pkg::strb_w-1:0]         pstrb,
  output logic [board_io_pkg::data_w-1:0]        prdata,
  output logic                                   pready,
  output logic                                   pslverr,
  output logic [board_io_pkg::num_rows-1:0]      led_row,
  output logic [7:0]                             led_col,
  output logic                                   lcd_e,
  output logic                                   lcd_rw,
  output logic                                   lcd_rs,
  output logic [3:0]                             lcd_db,
  output logic [7:0]                             gpio
);

  logic [7:0]             led_byte;
  logic [7:0]             lcd_byte;
  logic [7:0]             gpio_byte;
  board_io_pkg::row_idx_t row_idx;
  logic                   row_gate;

  mem_bus_if bus ();

  apb_access_fsm u_apb (
    .sys_clk (sys_clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .pstrb   (pstrb),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .bus     (bus.ctrl)
  );

  data_mem u_mem (.sys_clk(sys_clk), .rst_n(rst_n), .bus(bus.mem));

  io_regs u_io (
    .sys_clk   (sys_clk),
    .rst_n     (rst_n),
    .bus       (bus.io),
    .led_byte  (led_byte),
    .lcd_byte  (lcd_byte),
    .gpio_byte (gpio_byte)
  );

  row_scan_timer #(
    .PERIOD  (PERIOD),
    .GAP_ON  (GAP_ON),
    .GAP_OFF (GAP_OFF)
  ) u_scan (
    .sys_clk  (sys_clk),
    .rst_n    (rst_n),
    .row_idx  (row_idx),
    .row_gate (row_gate)
  );

  led_matrix_drive u_drive (
    .row_idx  (row_idx),
    .row_gate (row_gate),
    .led_byte (led_byte),
    .led_row  (led_row),
    .led_col  (led_col)
  );

  // lcd pin fields, bit 3 unused
  assign lcd_e  = lcd_byte[0];
  assign lcd_rw = lcd_byte[1];
  assign lcd_rs = lcd_byte[2];
  assign lcd_db = lcd_byte[7:4];

  assign gpio = gpio_byte;

endmodule

`default_nettype wire

/* source/data_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module data_mem (
  input  wire      sys_clk,
  input  wire      rst_n,
  mem_bus_if.mem   bus
);

  localparam int idx_w = $clog2(board_io_pkg::mem_words);

  logic [board_io_pkg::data_w-1:0] ram [board_io_pkg::mem_words];
  logic [board_io_pkg::data_w-1:0] rdata_q;
  logic [idx_w-1:0]                idx;
  logic                            hit;

  assign idx = bus.addr[idx_w-1:0];
  assign hit = bus.req && bus.sel_mem;

  // byte lanes written independently
  always_ff @(posedge sys_clk) begin
    if (hit && bus.we) begin
      for (int b = 0; b < board_io_pkg::strb_w; b++) begin
        if (bus.strb[b])
          ram[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
      end
    end
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n)
      rdata_q <= '0;
    else if (hit && !bus.we)
      rdata_q <= ram[idx]; // shows up in A2
  end

  assign bus.mem_rdata = rdata_q;

  // region decode lives in the FSM, the address must already be in range here
  a_addr_in_range : assert property (
    @(posedge sys_clk) disable iff (!rst_n)
    hit |-> (int'(bus.addr) < board_io_pkg::mem_words));

endmodule

`default_nettype wire

/* source/io_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module io_regs (
  input  wire          sys_clk,
  input  wire          rst_n,
  mem_bus_if.io        bus,
  output logic [7:0]   led_byte,
  output logic [7:0]   lcd_byte,
  output logic [7:0]   gpio_byte
);

  logic hit;
  logic hit_led_lcd;
  logic hit_gpio;
  logic [board_io_pkg::data_w-1:0] rdata_q;
  logic err_q;

  assign hit         = bus.req && bus.sel_io;
  assign hit_led_lcd = (bus.addr == board_io_pkg::io_led_lcd_addr);
  assign hit_gpio    = (bus.addr == board_io_pkg::io_gpio_addr);

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      led_byte  <= 8'h00;
      lcd_byte  <= 8'h00;
      gpio_byte <= 8'h00;
    end else if (hit && bus.we) begin
      if (hit_led_lcd) begin
        if (bus.strb[0])
          led_byte <= bus.wdata[7:0];
        if (bus.strb[1])
          lcd_byte <= bus.wdata[15:8];
      end else if (hit_gpio && bus.strb[0]) begin
        gpio_byte <= bus.wdata[7:0]; // high lane ignored
      end
    end
  end

  // readback and error for the response cycle
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata_q <= '0;
      err_q   <= 1'b0;
    end else begin
      err_q <= hit && !hit_led_lcd && !hit_gpio;
      if (hit) begin
        if (hit_led_lcd)
          rdata_q <= {lcd_byte, led_byte};
        else if (hit_gpio)
          rdata_q <= {8'h00, gpio_byte};
        else
          rdata_q <= '0; // unmapped
      end
    end
  end

  assign bus.io_rdata = rdata_q;
  assign bus.io_err   = err_q;

endmodule

`default_nettype wire

/* source/led_matrix_drive.sv */
`timescale 1ns/1ps
`default_nettype none

module led_matrix_drive (
  input  wire board_io_pkg::row_idx_t            row_idx,
  input  wire                                    row_gate,
  input  wire [7:0]                              led_byte,
  output logic [board_io_pkg::num_rows-1:0]      led_row,
  output logic [7:0]                             led_col
);

  localparam int led_row_idx = board_io_pkg::num_rows - 1;

  logic [board_io_pkg::num_rows-1:0] row_sel;

  // one-hot row, only inside the gate
  assign row_sel = row_gate ? (board_io_pkg::num_rows'(1) << row_idx) : '0;
  assign led_row = ~row_sel; // active low

  always_comb begin
    if (int'(row_idx) < led_row_idx)
      led_col = board_io_pkg::row_pattern[row_idx[1:0]];
    else if (int'(row_idx) == led_row_idx)
      led_col = led_byte; // last row shows the LED register
    else
      led_col = 8'h00;
  end

endmodule

`default_nettype wire

/* source/mem_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface mem_bus_if;

  logic                              req;   // one-cycle strobe
  logic                              we;
  logic [board_io_pkg::strb_w-1:0]   strb;
  logic [board_io_pkg::addr_w-1:0]   addr;
  logic [board_io_pkg::data_w-1:0]   wdata;
  logic                              sel_mem;
  logic                              sel_io;

  // responses, valid the cycle after req
  logic [board_io_pkg::data_w-1:0]   mem_rdata;
  logic [board_io_pkg::data_w-1:0]   io_rdata;
  logic                              io_err;

  modport ctrl (
    output req, we, strb, addr, wdata, sel_mem, sel_io,
    input  mem_rdata, io_rdata, io_err
  );

  modport mem (
    input  req, we, strb, addr, wdata, sel_mem,
    output mem_rdata
  );

  modport io (
    input  req, we, strb, addr, wdata, sel_io,
    output io_rdata, io_err
  );

endinterface

`default_nettype wire

/* source/row_scan_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module row_scan_timer #(
  parameter int PERIOD  = 27000,
  parameter int GAP_ON  = 100,
  parameter int GAP_OFF = 2000
) (
  input  wire                     sys_clk,
  input  wire                     rst_n,
  output board_io_pkg::row_idx_t  row_idx,
  output logic                    row_gate
);

  localparam int cnt_w = (PERIOD > 1) ? $clog2(PERIOD) : 1;

  logic [cnt_w-1:0] counter;
  logic             wrap;

  assign wrap = (counter == cnt_w'(PERIOD - 1));

  // dwell counter, free running
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n)
      counter <= '0;
    else if (wrap)
      counter <= '0;
    else
      counter <= counter + 1'b1;
  end

  // next row starts together with counter 0
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n)
      row_idx <= '0;
    else if (wrap) begin
      if (row_idx == board_io_pkg::row_idx_t'(board_io_pkg::num_rows - 1))
        row_idx <= '0;
      else
        row_idx <= row_idx + 1'b1;
    end
  end

  // dead bands at both ends of the dwell
  assign row_gate = (counter >= cnt_w'(GAP_ON)) &&
                    (counter < cnt_w'(PERIOD - GAP_OFF));

  a_row_in_range : assert property (
    @(posedge sys_clk) disable iff (!rst_n)
    int'(row_idx) < board_io_pkg::num_rows);

endmodule

`default_nettype wire

/* verification/board_io_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module board_io_tb;

  localparam int scan_period  = 20;
  localparam int gap_on       = 2;
  localparam int gap_off      = 4;
  localparam int rows         = 5;
  localparam int frame_cycles = rows * scan_period;
  localparam int tbl_len      = 24;
  localparam int timeout_cycles = 4 * tbl_len * 3 + 400;
  localparam logic [31:0] seed = 32'h8f7e_55e3;

  typedef struct packed {
    logic        wr;
    logic [7:0]  addr;
    logic [1:0]  strb;
    logic [15:0] data;
    logic [15:0] exp_rdata;
    logic        exp_err;
  } entry_t;

  logic        sys_clk = 1'b0;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [15:0] pwdata;
  logic [1:0]  pstrb;
  logic [15:0] prdata;
  logic        pready;
  logic        pslverr;
  logic [4:0]  led_row;
  logic [7:0]  led_col;
  logic        lcd_e;
  logic        lcd_rw;
  logic        lcd_rs;
  logic [3:0]  lcd_db;
  logic [7:0]  gpio;

  entry_t      tbl [tbl_len];
  int          n_ent;
  int          errors;
  int          checks;
  int          cycles;
  logic [31:0] lfsr;
  logic [7:0]  led_sh;   // expected register contents
  logic [7:0]  lcd_sh;
  logic [7:0]  gpio_sh;
  logic [15:0] got_rdata;
  logic        got_err;
  logic        scan_on;
  int          m_cnt = 0; // scan model
  int          m_row = 0;
  logic [4:0]  exp_row;
  logic [7:0]  exp_col;

  board_io_top #(
    .PERIOD  (scan_period),
    .GAP_ON  (gap_on),
    .GAP_OFF (gap_off)
  ) DUT (
    .sys_clk (sys_clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .pstrb   (pstrb),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .led_row (led_row),
    .led_col (led_col),
    .lcd_e   (lcd_e),
    .lcd_rw  (lcd_rw),
    .lcd_rs  (lcd_rs),
    .lcd_db  (lcd_db),
    .gpio    (gpio)
  );

  always #10 sys_clk = ~sys_clk;

  always @(posedge sys_clk) begin
    cycles++;
    if (cycles >= timeout_cycles) begin
      $display("run stopped, no finish after %0d cycles", cycles);
      $display("checks %0d, errors %0d", checks, errors);
      $display("tests failed");
      $finish;
    end
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one lfsr step per bit
  task automatic take_word(output logic [15:0] w);
    for (int i = 0; i < 16; i++) begin
      w[i] = lfsr[0];
      lfsr = lfsr_step(lfsr);
    end
  endtask

  function automatic logic [15:0] merge_bytes(input logic [15:0] old_w,
                                              input logic [15:0] new_w,
                                              input logic [1:0]  strb);
    merge_bytes[7:0]  = strb[0] ? new_w[7:0]  : old_w[7:0];
    merge_bytes[15:8] = strb[1] ? new_w[15:8] : old_w[15:8];
  endfunction

  task automatic add_entry(input logic wr, input logic [7:0] addr, input logic [1:0] strb,
                           input logic [15:0] data, input logic [15:0] exp_rdata,
                           input logic exp_err);
    tbl[n_ent] = '{wr, addr, strb, data, exp_rdata, exp_err};
    n_ent++;
  endtask

  task automatic build_table();
    logic [15:0] w [4];
    logic [7:0]  mem_addr [4];
    logic [15:0] a, b, c, d, e, f, g, h;
    mem_addr = '{8'h00, 8'h05, 8'h3c, 8'h7f};
    for (int i = 0; i < 4; i++)
      take_word(w[i]);
    take_word(a);
    take_word(b);
    take_word(c);
    take_word(d);
    take_word(e);
    take_word(f);
    take_word(g);
    take_word(h);
    add_entry(1'b0, 8'h80, 2'b11, 16'h0000, 16'h0000, 1'b0); // reset value
    for (int i = 0; i < 4; i++)
      add_entry(1'b1, mem_addr[i], 2'b11, w[i], 16'h0000, 1'b0);
    for (int i = 0; i < 4; i++)
      add_entry(1'b0, mem_addr[i], 2'b11, 16'h0000, w[i], 1'b0);
    add_entry(1'b1, 8'h21, 2'b11, a, 16'h0000, 1'b0);
    add_entry(1'b1, 8'h21, 2'b01, b, 16'h0000, 1'b0);
    add_entry(1'b0, 8'h21, 2'b11, 16'h0000, merge_bytes(a, b, 2'b01), 1'b0);
    add_entry(1'b1, 8'h22, 2'b11, c, 16'h0000, 1'b0);
    add_entry(1'b1, 8'h22, 2'b10, d, 16'h0000, 1'b0);
    add_entry(1'b0, 8'h22, 2'b11, 16'h0000, merge_bytes(c, d, 2'b10), 1'b0);
    add_entry(1'b1, 8'h80, 2'b11, e, 16'h0000, 1'b0);
    add_entry(1'b1, 8'h80, 2'b10, f, 16'h0000, 1'b0);
    add_entry(1'b0, 8'h80, 2'b11, 16'h0000, merge_bytes(e, f, 2'b10), 1'b0);
    add_entry(1'b1, 8'h81, 2'b11, g, 16'h0000, 1'b0);
    add_entry(1'b0, 8'h81, 2'b11, 16'h0000, {8'h00, g[7:0]}, 1'b0);
    add_entry(1'b1, 8'h82, 2'b11, h, 16'h0000, 1'b1); // unmapped
    add_entry(1'b0, 8'hf0, 2'b11, 16'h0000, 16'h0000, 1'b1);
    add_entry(1'b0, 8'h80, 2'b11, 16'h0000, merge_bytes(e, f, 2'b10), 1'b0);
    add_entry(1'b0, 8'h81, 2'b11, 16'h0000, {8'h00, g[7:0]}, 1'b0);
  endtask

  // setup, A1, then wait in A2 for pready
  task automatic apb_transfer(input logic wr, input logic [7:0] addr, input logic [1:0] strb,
                              input logic [15:0] data, output logic [15:0] rdata,
                              output logic err);
    @(posedge sys_clk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pstrb   = strb;
    pwdata  = data;
    @(posedge sys_clk);
    #1;
    penable = 1'b1;
    @(negedge sys_clk);
    while (!pready)
      @(negedge sys_clk);
    rdata = prdata;
    err   = pslverr;
    @(posedge sys_clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic check_pins(input int idx);
    checks += 5;
    if (lcd_e !== lcd_sh[0]) begin
      errors++;
      $display("ERR lcd_e entry %0d: got %h exp %h", idx, lcd_e, lcd_sh[0]);
    end
    if (lcd_rw !== lcd_sh[1]) begin
      errors++;
      $display("ERR lcd_rw entry %0d: got %h exp %h", idx, lcd_rw, lcd_sh[1]);
    end
    if (lcd_rs !== lcd_sh[2]) begin
      errors++;
      $display("ERR lcd_rs entry %0d: got %h exp %h", idx, lcd_rs, lcd_sh[2]);
    end
    if (lcd_db !== lcd_sh[7:4]) begin
      errors++;
      $display("ERR lcd_db entry %0d: got %h exp %h", idx, lcd_db, lcd_sh[7:4]);
    end
    if (gpio !== gpio_sh) begin
      errors++;
      $display("ERR gpio entry %0d: got %h exp %h", idx, gpio, gpio_sh);
    end
  endtask

  // counter and row from the scan timing rules
  always @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      m_cnt <= 0;
      m_row <= 0;
    end else if (m_cnt == scan_period - 1) begin
      m_cnt <= 0;
      m_row <= (m_row == rows - 1) ? 0 : m_row + 1;
    end else begin
      m_cnt <= m_cnt + 1;
    end
  end

  always @(negedge sys_clk) begin
    if (scan_on) begin
      exp_row = 5'b11111;
      if (m_cnt >= gap_on && m_cnt < scan_period - gap_off)
        exp_row[m_row] = 1'b0;
      exp_col = (m_row < rows - 1) ? (8'h80 >> m_row) : led_sh;
      checks += 2;
      if (led_row !== exp_row) begin
        errors++;
        $display("ERR led_row row %0d cnt %0d: got %h exp %h", m_row, m_cnt, led_row, exp_row);
      end
      if (led_col !== exp_col) begin
        errors++;
        $display("ERR led_col row %0d cnt %0d: got %h exp %h", m_row, m_cnt, led_col, exp_col);
      end
    end
  end

  initial begin
    rst_n   = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = 8'h00;
    pwdata  = 16'h0000;
    pstrb   = 2'b00;
    errors  = 0;
    checks  = 0;
    cycles  = 0;
    n_ent   = 0;
    scan_on = 1'b0;
    lfsr    = seed;
    led_sh  = 8'h00;
    lcd_sh  = 8'h00;
    gpio_sh = 8'h00;
    build_table();

    repeat (16) @(posedge sys_clk);
    #1 rst_n = 1'b1;
    @(negedge sys_clk);
    checks += 3;
    if (pready !== 1'b0) begin
      errors++;
      $display("ERR pready after reset: got %h exp %h", pready, 1'b0);
    end
    if (pslverr !== 1'b0) begin
      errors++;
      $display("ERR pslverr after reset: got %h exp %h", pslverr, 1'b0);
    end
    if (led_col !== 8'h80) begin
      errors++;
      $display("ERR led_col after reset: got %h exp %h", led_col, 8'h80);
    end

    for (int i = 0; i < n_ent; i++) begin
      apb_transfer(tbl[i].wr, tbl[i].addr, tbl[i].strb, tbl[i].data, got_rdata, got_err);
      checks++;
      if (got_err !== tbl[i].exp_err) begin
        errors++;
        $display("ERR pslverr entry %0d: got %h exp %h", i, got_err, tbl[i].exp_err);
      end
      if (!tbl[i].wr || tbl[i].exp_err) begin
        checks++;
        if (got_rdata !== tbl[i].exp_rdata) begin
          errors++;
          $display("ERR prdata entry %0d: got %h exp %h", i, got_rdata, tbl[i].exp_rdata);
        end
      end
      if (tbl[i].wr && !tbl[i].exp_err) begin
        if (tbl[i].addr == 8'h80 && tbl[i].strb[0])
          led_sh = tbl[i].data[7:0];
        if (tbl[i].addr == 8'h80 && tbl[i].strb[1])
          lcd_sh = tbl[i].data[15:8];
        if (tbl[i].addr == 8'h81 && tbl[i].strb[0])
          gpio_sh = tbl[i].data[7:0];
      end
      check_pins(i);
    end

    // apb idle from here, two frames from row 0
    @(posedge sys_clk);
    #1;
    while (!(m_row == 0 && m_cnt == 0)) begin
      @(posedge sys_clk);
      #1;
    end
    scan_on = 1'b1;
    repeat (2 * frame_cycles) @(posedge sys_clk);
    #1 scan_on = 1'b0;

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
